// ==== logic/rename_cfg_pkg.sv ====
`default_nettype none

package rename_cfg_pkg;

    // rename group width
    localparam int WAYS = 3;                        // instructions renamed per cycle
    localparam int WAY_CNT_W = $clog2(WAYS + 1);    // holds 0..WAYS

    // register files
    localparam int NUM_AR = 32;
    localparam int NUM_PR = 64;

    localparam int AR_W = $clog2(NUM_AR);           // 5 bits
    localparam int PR_W = $clog2(NUM_PR);           // 6 bits

    // tags not claimed by the identity map at reset
    localparam int FL_DEPTH = NUM_PR - NUM_AR;

    // one wrap bit above the address so full and empty differ
    localparam int FL_PTR_W = $clog2(FL_DEPTH) + 1;

endpackage

`default_nettype wire

// ==== logic/rename_types_pkg.sv ====
`default_nettype none

package rename_types_pkg;

    import rename_cfg_pkg::*;

    typedef logic [AR_W-1:0] ar_idx_t;
    typedef logic [PR_W-1:0] pr_tag_t;

    // one decoded instruction as seen by rename
    typedef struct packed {
        logic    valid;
        logic    has_dest;
        ar_idx_t dest_ar;
        ar_idx_t src1_ar;
        ar_idx_t src2_ar;
    } rename_slot_t;

    typedef rename_slot_t [WAYS-1:0] rename_req_t;     // slot 0 is oldest

    typedef struct packed {
        pr_tag_t src1_tag;
        logic    src1_ready;
        pr_tag_t src2_tag;
        logic    src2_ready;
        pr_tag_t new_tag;
        pr_tag_t old_tag;                                // Told
    } rename_resp_slot_t;

    typedef rename_resp_slot_t [WAYS-1:0] rename_resp_t;

    typedef struct packed {
        logic    valid;
        pr_tag_t tag;
    } cdb_lane_t;

    typedef cdb_lane_t [WAYS-1:0] cdb_packet_t;

    typedef struct packed {
        logic    valid;
        ar_idx_t ar;
        pr_tag_t new_tag;
    } retire_slot_t;

    typedef retire_slot_t [WAYS-1:0] retire_packet_t;  // lane 0 is oldest

    typedef pr_tag_t [NUM_AR-1:0] map_array_t;

endpackage

`default_nettype wire

// ==== logic/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  logic [rename_cfg_pkg::WAY_CNT_W-1:0]                 alloc_count,
    output rename_types_pkg::pr_tag_t [rename_cfg_pkg::WAYS-1:0] alloc_tags,
    output logic [rename_cfg_pkg::FL_PTR_W-1:0]                  free_count,
    input  logic [rename_cfg_pkg::WAYS-1:0]                      release_valid,
    input  rename_types_pkg::pr_tag_t [rename_cfg_pkg::WAYS-1:0] release_tags,
    input  logic                                                 recover
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int ADDR_W = FL_PTR_W - 1;

    pr_tag_t                       mem [FL_DEPTH];
    logic [FL_PTR_W-1:0]           spec_head;       // next tag handed out
    logic [FL_PTR_W-1:0]           commit_head;     // oldest tag not yet retired
    logic [FL_PTR_W-1:0]           tail;            // next slot for a released tag
    logic [FL_PTR_W-1:0]           release_count;
    logic [WAYS-1:0][FL_PTR_W-1:0] rd_ptr;
    logic [WAYS-1:0][FL_PTR_W-1:0] wr_ptr;

    // peek at the next WAYS tags, the top picks how many it takes
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            rd_ptr[i]     = spec_head + FL_PTR_W'(i);
            alloc_tags[i] = mem[rd_ptr[i][ADDR_W-1:0]];
        end
    end

    // released tags pack at the tail in lane order
    always_comb begin
        release_count = '0;
        for (int i = 0; i < WAYS; i++) begin
            wr_ptr[i] = tail + release_count;
            if (release_valid[i]) begin
                release_count = release_count + FL_PTR_W'(1);
            end
        end
    end

    assign free_count = tail - spec_head;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                mem[i] <= pr_tag_t'(NUM_AR + i);
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (release_valid[i]) begin
                    mem[wr_ptr[i][ADDR_W-1:0]] <= release_tags[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= FL_PTR_W'(FL_DEPTH);     // full
        end else begin
            tail        <= tail + release_count;
            // one retired allocation per released Told
            commit_head <= commit_head + release_count;
            if (recover) begin
                spec_head <= commit_head;           // drop wrong-path allocations
            end else begin
                spec_head <= spec_head + FL_PTR_W'(alloc_count);
            end
        end
    end

    alloc_within_free: assert property (@(posedge clock) disable iff (reset)
        FL_PTR_W'(alloc_count) <= free_count);

    // a release with no allocation behind it pushes the buffer past its depth
    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        free_count <= FL_PTR_W'(FL_DEPTH));

endmodule

`default_nettype wire

// ==== logic/spec_map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module spec_map_table (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  rename_types_pkg::rename_req_t                        rename_req,
    input  rename_types_pkg::pr_tag_t [rename_cfg_pkg::WAYS-1:0] new_tags,
    input  logic [rename_cfg_pkg::WAYS-1:0]                      alloc_fire,
    input  rename_types_pkg::cdb_packet_t                        cdb,
    input  rename_types_pkg::map_array_t                         arch_map,
    input  logic                                                 recover,
    output rename_types_pkg::rename_resp_t                       rename_resp
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    map_array_t                  map_q;
    logic [NUM_AR-1:0]           ready_q;
    map_array_t [WAYS:0]         map_stage;     // stage i holds writes of slots before i
    logic [WAYS:0][NUM_AR-1:0]   busy_stage;    // registers redefined by earlier slots
    logic [NUM_AR-1:0]           wake;
    logic [NUM_AR-1:0]           ready_d;

    // cdb wakeup against the registered map
    always_comb begin
        for (int j = 0; j < NUM_AR; j++) begin
            wake[j] = 1'b0;
            for (int k = 0; k < WAYS; k++) begin
                if (cdb[k].valid && map_q[j] == cdb[k].tag) begin
                    wake[j] = 1'b1;
                end
            end
        end
    end

    // apply the group's destinations in program order
    always_comb begin
        map_stage[0]  = map_q;
        busy_stage[0] = '0;
        for (int i = 0; i < WAYS; i++) begin
            map_stage[i+1]  = map_stage[i];
            busy_stage[i+1] = busy_stage[i];
            if (alloc_fire[i]) begin
                map_stage[i+1][rename_req[i].dest_ar]  = new_tags[i];
                busy_stage[i+1][rename_req[i].dest_ar] = 1'b1;
            end
        end
    end

    // slot i looks up stage i, so it sees slots 0..i-1 but not the cdb of this cycle
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            rename_resp[i].src1_tag   = map_stage[i][rename_req[i].src1_ar];
            rename_resp[i].src1_ready = ready_q[rename_req[i].src1_ar]
                                        & ~busy_stage[i][rename_req[i].src1_ar];
            rename_resp[i].src2_tag   = map_stage[i][rename_req[i].src2_ar];
            rename_resp[i].src2_ready = ready_q[rename_req[i].src2_ar]
                                        & ~busy_stage[i][rename_req[i].src2_ar];
            rename_resp[i].new_tag    = new_tags[i];
            rename_resp[i].old_tag    = map_stage[i][rename_req[i].dest_ar];
        end
    end

    // wakeup first, then the new destinations go busy
    assign ready_d = (ready_q | wake) & ~busy_stage[WAYS];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < NUM_AR; j++) begin
                map_q[j] <= pr_tag_t'(j);               // identity map
            end
            ready_q <= '1;
        end else if (recover) begin
            map_q   <= arch_map;
            ready_q <= '1;                              // committed values are all written
        end else begin
            map_q   <= map_stage[WAYS];
            ready_q <= ready_d;
        end
    end

    // r0 keeps tag 0 and stays ready
    zero_reg_fixed: assert property (@(posedge clock) disable iff (reset)
        map_q[0] == '0 && ready_q[0]);

endmodule

`default_nettype wire

// ==== logic/arch_map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_map_table (
    input  logic                            clock,
    input  logic                            reset,
    input  rename_types_pkg::retire_packet_t retire,
    input  logic                            recover,
    output rename_types_pkg::map_array_t    arch_map
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    map_array_t      arch_next;
    logic [WAYS-1:0] retire_valid;
    logic [WAYS-1:0] zero_write;

    // later lanes are younger and overwrite earlier ones
    always_comb begin
        arch_next = arch_map;
        for (int i = 0; i < WAYS; i++) begin
            retire_valid[i] = retire[i].valid;
            zero_write[i]   = retire[i].valid && retire[i].ar == '0;
            if (retire[i].valid) begin
                arch_next[retire[i].ar] = retire[i].new_tag;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < NUM_AR; j++) begin
                arch_map[j] <= pr_tag_t'(j);
            end
        end else begin
            arch_map <= arch_next;
        end
    end

    // spec map reloads from arch_map on the same edge, so retire must be quiet
    no_retire_in_recovery: assert property (@(posedge clock) disable iff (reset)
        recover |-> retire_valid == '0);

    no_retire_to_r0: assert property (@(posedge clock) disable iff (reset)
        zero_write == '0);

endmodule

`default_nettype wire

// ==== logic/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  rename_types_pkg::rename_req_t                        rename_req,
    input  rename_types_pkg::cdb_packet_t                        cdb,
    input  rename_types_pkg::retire_packet_t                     retire,
    input  rename_types_pkg::pr_tag_t [rename_cfg_pkg::WAYS-1:0] retire_told,
    input  logic                                                 recover,
    output rename_types_pkg::rename_resp_t                       rename_resp,
    output logic                                                 stall
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    pr_tag_t [WAYS-1:0]   alloc_tags;
    pr_tag_t [WAYS-1:0]   new_tags;
    logic [FL_PTR_W-1:0]  free_count;
    logic [WAYS-1:0]      alloc_mask;
    logic [WAYS-1:0]      alloc_fire;
    logic [WAYS-1:0]      release_valid;
    logic [WAY_CNT_W-1:0] need_count;
    logic [WAY_CNT_W-1:0] alloc_count;
    map_array_t           arch_map;

    // slots that write r0 or have no dest skip the free list
    always_comb begin
        need_count = '0;
        for (int i = 0; i < WAYS; i++) begin
            alloc_mask[i] = rename_req[i].valid && rename_req[i].has_dest
                            && rename_req[i].dest_ar != '0;
            new_tags[i]   = alloc_tags[need_count];     // compact onto allocating slots
            if (alloc_mask[i]) begin
                need_count = need_count + WAY_CNT_W'(1);
            end
        end
    end

    assign stall       = recover || (FL_PTR_W'(need_count) > free_count);
    assign alloc_fire  = stall ? '0 : alloc_mask;
    assign alloc_count = stall ? '0 : need_count;

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            release_valid[i] = retire[i].valid;
        end
    end

    free_list u_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc_count   (alloc_count),
        .alloc_tags    (alloc_tags),
        .free_count    (free_count),
        .release_valid (release_valid),
        .release_tags  (retire_told),
        .recover       (recover)
    );

    spec_map_table u_spec_map_table (
        .clock       (clock),
        .reset       (reset),
        .rename_req  (rename_req),
        .new_tags    (new_tags),
        .alloc_fire  (alloc_fire),
        .cdb         (cdb),
        .arch_map    (arch_map),
        .recover     (recover),
        .rename_resp (rename_resp)
    );

    arch_map_table u_arch_map_table (
        .clock    (clock),
        .reset    (reset),
        .retire   (retire),
        .recover  (recover),
        .arch_map (arch_map)
    );

endmodule

`default_nettype wire

// ==== dv/rename_model.svh ====
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH
`default_nettype none

typedef struct packed {
    ar_idx_t ar;
    pr_tag_t new_tag;
    pr_tag_t told;
} inflight_t;

map_array_t        spec_map;
logic [NUM_AR-1:0] spec_ready;
map_array_t        arch_model;
pr_tag_t           free_q[$];                   // front is the next tag handed out
inflight_t         inflight_q[$];               // oldest first
int                tag_errors;
int                ready_errors;
int                stall_errors;

task automatic reset_model();
    free_q.delete();
    inflight_q.delete();
    for (int j = 0; j < NUM_AR; j++) begin
        spec_map[j]   = pr_tag_t'(j);
        arch_model[j] = pr_tag_t'(j);
    end
    spec_ready = '1;
    for (int i = 0; i < FL_DEPTH; i++) begin
        free_q.push_back(pr_tag_t'(NUM_AR + i));
    end
    tag_errors   = 0;
    ready_errors = 0;
    stall_errors = 0;
endtask

task automatic check_tag(input string name, input pr_tag_t got, input pr_tag_t exp);
    if (got !== exp) begin
        tag_errors++;
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        ready_errors++;
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_stall(input logic got, input logic exp);
    if (got !== exp) begin
        stall_errors++;
        $display("** Error: stall = %h, expected %h at %0t", got, exp, $time);
    end
endtask

// one clock edge of the rename stage, checking the responses seen before it
task automatic step_model(input rename_req_t req, input rename_resp_t resp,
                          input logic stall_seen, input cdb_packet_t bus,
                          input int retire_n, input logic recover_now);
    map_array_t        map_next;
    logic [NUM_AR-1:0] busy;
    logic [NUM_AR-1:0] woken;
    int                need;
    logic              exp_stall;
    inflight_t         entry;
    ar_idx_t           s1;
    ar_idx_t           s2;
    woken = '0;
    for (int j = 0; j < NUM_AR; j++) begin
        for (int k = 0; k < WAYS; k++) begin
            if (bus[k].valid && spec_map[j] == bus[k].tag) begin
                woken[j] = 1'b1;                // wakeup sees the map before this group
            end
        end
    end
    need = 0;
    for (int i = 0; i < WAYS; i++) begin
        if (req[i].valid && req[i].has_dest && req[i].dest_ar != '0) begin
            need++;
        end
    end
    exp_stall = recover_now || (need > free_q.size());
    check_stall(stall_seen, exp_stall);
    for (int i = 0; i < retire_n; i++) begin
        entry = inflight_q.pop_front();
        arch_model[entry.ar] = entry.new_tag;
        free_q.push_back(entry.told);
    end
    map_next = spec_map;
    busy     = '0;
    for (int i = 0; i < WAYS; i++) begin
        if (!exp_stall && req[i].valid) begin
            s1 = req[i].src1_ar;
            s2 = req[i].src2_ar;
            check_tag($sformatf("rename_resp[%0d].src1_tag", i), resp[i].src1_tag, map_next[s1]);
            check_ready($sformatf("rename_resp[%0d].src1_ready", i), resp[i].src1_ready,
                        spec_ready[s1] & ~busy[s1]);
            check_tag($sformatf("rename_resp[%0d].src2_tag", i), resp[i].src2_tag, map_next[s2]);
            check_ready($sformatf("rename_resp[%0d].src2_ready", i), resp[i].src2_ready,
                        spec_ready[s2] & ~busy[s2]);
            if (req[i].has_dest && req[i].dest_ar != '0) begin
                entry.ar      = req[i].dest_ar;
                entry.new_tag = free_q.pop_front();
                entry.told    = map_next[entry.ar];
                check_tag($sformatf("rename_resp[%0d].new_tag", i), resp[i].new_tag,
                          entry.new_tag);
                check_tag($sformatf("rename_resp[%0d].old_tag", i), resp[i].old_tag,
                          entry.told);
                map_next[entry.ar] = entry.new_tag;
                busy[entry.ar]     = 1'b1;
                inflight_q.push_back(entry);
            end
        end
    end
    if (recover_now) begin
        for (int i = inflight_q.size() - 1; i >= 0; i--) begin
            free_q.push_front(inflight_q[i].new_tag);   // wrong-path tags go back in order
        end
        inflight_q.delete();
        spec_map   = arch_model;
        spec_ready = '1;
    end else begin
        spec_map   = map_next;
        spec_ready = (spec_ready | woken) & ~busy;
    end
endtask

`default_nettype wire
`endif

// ==== dv/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int STIM_CYCLES = 1500;
    localparam int CYCLE_LIMIT = 2000;          // stimulus, reset and margin

    logic               clock;
    logic               reset;
    rename_req_t        rename_req;
    cdb_packet_t        cdb;
    retire_packet_t     retire;
    pr_tag_t [WAYS-1:0] retire_told;
    logic               recover;
    rename_resp_t       rename_resp;
    logic               stall;
    integer             seed;
    int                 cycle_count = 0;
    int                 retire_n;

    `include "rename_model.svh"

    rename_top u_dut (
        .clock       (clock),
        .reset       (reset),
        .rename_req  (rename_req),
        .cdb         (cdb),
        .retire      (retire),
        .retire_told (retire_told),
        .recover     (recover),
        .rename_resp (rename_resp),
        .stall       (stall)
    );

    function automatic int unsigned pick_below(input int unsigned range);
        return $unsigned($random(seed)) % range;
    endfunction

    task automatic drive_cycle();
        recover = (pick_below(40) == 0);
        for (int i = 0; i < WAYS; i++) begin
            rename_req[i].valid    = (pick_below(4) != 0);
            rename_req[i].has_dest = (pick_below(4) != 0);
            rename_req[i].dest_ar  = ar_idx_t'($random(seed));
            rename_req[i].src1_ar  = ar_idx_t'($random(seed));
            rename_req[i].src2_ar  = ar_idx_t'($random(seed));
            cdb[i] = '0;
            if (inflight_q.size() > 0 && pick_below(2) == 0) begin
                cdb[i].valid = 1'b1;
                cdb[i].tag   = inflight_q[pick_below(inflight_q.size())].new_tag;
            end
        end
        retire_n = recover ? 0 : int'(pick_below(4));     // nothing retires during recovery
        if (retire_n > inflight_q.size()) begin
            retire_n = inflight_q.size();
        end
        for (int i = 0; i < WAYS; i++) begin
            retire[i]      = '0;
            retire_told[i] = '0;
            if (i < retire_n) begin
                retire[i].valid   = 1'b1;
                retire[i].ar      = inflight_q[i].ar;
                retire[i].new_tag = inflight_q[i].new_tag;
                retire_told[i]    = inflight_q[i].told;
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: stimulus still running after %0d cycles", cycle_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed        = 32'h4226_1239;
        reset       = 1'b1;
        recover     = 1'b0;
        rename_req  = '0;
        cdb         = '0;
        retire      = '0;
        retire_told = '0;
        reset_model();
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int n = 0; n < STIM_CYCLES; n++) begin
            drive_cycle();
            #10;                                // outputs settled, edge still 8 ns away
            step_model(rename_req, rename_resp, stall, cdb, retire_n, recover);
            @(posedge clock);
            #2;
        end
        $display("errors: tag %0d, ready %0d, stall %0d", tag_errors, ready_errors, stall_errors);
        if (tag_errors + ready_errors + stall_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
logic/rename_cfg_pkg.sv
logic/rename_types_pkg.sv
logic/free_list.sv
logic/spec_map_table.sv
logic/arch_map_table.sv
logic/rename_top.sv
dv/rename_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module rename_tb -o rename_sim
./obj_dir/rename_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a final report, see sim.log"
    exit 1
fi
